// File: logic/core_pkg.sv
package core_pkg;

    localparam int xlen = 64;

    typedef logic [5:0] preg_t;

    typedef struct packed {
        logic       flag;
        logic [4:0] idx;
    } rob_tag_t;

    typedef enum logic [1:0] {
        size_b,
        size_h,
        size_w,
        size_d
    } ls_size_t;

    typedef struct packed {
        logic            is_load;
        logic            is_store;
        logic            is_unsigned;
        ls_size_t        size;
        preg_t           prd;
        rob_tag_t        tag;
        logic [xlen-1:0] src1;
        logic [xlen-1:0] src2;
        logic [xlen-1:0] imm;
    } mem_instr_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
    } flush_t;

    typedef struct packed {
        logic            valid;
        logic            need_wb;
        logic            mmio;
        preg_t           prd;
        rob_tag_t        tag;
        logic [xlen-1:0] data;
    } wb_result_t;

    // inclusive mmio window, never sent to the data bus
    localparam logic [xlen-1:0] mmio_base  = 64'h0000_0000_3000_0000;
    localparam logic [xlen-1:0] mmio_limit = 64'h0000_0000_4070_0000;

endpackage

// File: logic/tbus_pkg.sv
package tbus_pkg;

    typedef enum logic {
        tbus_read  = 1'b0,
        tbus_write = 1'b1
    } tbus_op_t;

    typedef struct packed {
        logic        valid;
        tbus_op_t    op;
        logic [63:0] index;
        logic [63:0] write_data;
        // one mask bit per data bit
        logic [63:0] write_mask;
    } tbus_req_t;

    typedef struct packed {
        logic        ready;
        logic        done;
        logic [63:0] read_data;
    } tbus_rsp_t;

endpackage

// File: logic/store_align.sv
`timescale 1ns/1ps

module store_align (
    input  logic [2:0]         addr_low,
    input  core_pkg::ls_size_t size,
    input  logic [63:0]        src2,
    output logic [63:0]        store_data,
    output logic [63:0]        store_mask
);

    logic [5:0] shift;

    assign shift      = {addr_low, 3'b000};
    assign store_data = src2 << shift;

    always_comb begin
        case (size)
            core_pkg::size_b: begin
                store_mask = {56'h0, 8'hff} << shift;
            end
            core_pkg::size_h: begin
                store_mask = {48'h0, 16'hffff} << shift;
            end
            core_pkg::size_w: begin
                store_mask = {32'h0, 32'hffff_ffff} << shift;
            end
            default: begin
                store_mask = '1;
            end
        endcase
    end

endmodule

// File: logic/load_align.sv
`timescale 1ns/1ps

module load_align (
    input  logic [2:0]         addr_low,
    input  core_pkg::ls_size_t size,
    input  logic               is_unsigned,
    input  logic [63:0]        read_data,
    output logic [63:0]        load_data
);

    logic [63:0] shifted;

    // bring the addressed lane down to bit 0
    always_comb begin
        case (size)
            core_pkg::size_b: shifted = read_data >> {addr_low, 3'b000};
            core_pkg::size_h: shifted = read_data >> {addr_low[2:1], 4'b0000};
            core_pkg::size_w: shifted = read_data >> {addr_low[2], 5'b00000};
            default:          shifted = read_data;
        endcase
    end

    always_comb begin
        case (size)
            core_pkg::size_b: begin
                load_data = is_unsigned ? {56'h0, shifted[7:0]} :
                                          {{56{shifted[7]}}, shifted[7:0]};
            end
            core_pkg::size_h: begin
                load_data = is_unsigned ? {48'h0, shifted[15:0]} :
                                          {{48{shifted[15]}}, shifted[15:0]};
            end
            core_pkg::size_w: begin
                load_data = is_unsigned ? {32'h0, shifted[31:0]} :
                                          {{32{shifted[31]}}, shifted[31:0]};
            end
            default: begin
                load_data = shifted;
            end
        endcase
    end

endmodule

// File: logic/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
    parameter int ram_latency = 3,
    parameter int ram_words   = 256
) (
    input  logic                clock,
    input  logic                reset_n,
    input  tbus_pkg::tbus_req_t req,
    output tbus_pkg::tbus_rsp_t rsp
);

    localparam int cnt_w = (ram_latency > 1) ? $clog2(ram_latency) : 1;
    localparam int idx_w = (ram_words > 1) ? $clog2(ram_words) : 1;

    logic [63:0]        mem [ram_words];
    logic               busy;
    logic [cnt_w-1:0]   cnt;
    logic               accept;
    logic               done;
    logic [60:0]        word_full;
    logic [idx_w-1:0]   word_idx;
    logic [idx_w-1:0]   idx_q;
    tbus_pkg::tbus_op_t op_q;
    logic [63:0]        data_q;
    logic [63:0]        mask_q;

    assign accept = req.valid & ~busy;
    assign done   = busy & (cnt == '0);

    // word index wraps at the RAM depth
    assign word_full = req.index[63:3] % 61'(ram_words);
    assign word_idx  = word_full[idx_w-1:0];

    always_comb begin
        rsp.ready     = ~busy;
        rsp.done      = done;
        rsp.read_data = (done && op_q == tbus_pkg::tbus_read) ? mem[idx_q] : '0;
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (accept) begin
            busy <= 1'b1;
            cnt  <= cnt_w'(ram_latency - 1);
        end else if (done) begin
            busy <= 1'b0;
        end else if (busy) begin
            cnt <= cnt - cnt_w'(1);
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            op_q   <= req.op;
            idx_q  <= word_idx;
            data_q <= req.write_data;
            mask_q <= req.write_mask;
        end
    end

    // write lands at the end of the done cycle
    always_ff @(posedge clock) begin
        if (done && op_q == tbus_pkg::tbus_write) begin
            mem[idx_q] <= (mem[idx_q] & ~mask_q) | (data_q & mask_q);
        end
    end

    // the requester waits for done before it asks again
    assert property (@(posedge clock) disable iff (!reset_n)
        busy |-> !req.valid);

endmodule

// File: logic/mem_unit.sv
`timescale 1ns/1ps

module mem_unit (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 instr_valid,
    input  core_pkg::mem_instr_t instr,
    input  core_pkg::flush_t     flush,
    output logic                 instr_ready,
    output core_pkg::wb_result_t wb,
    output tbus_pkg::tbus_req_t  req,
    input  tbus_pkg::tbus_rsp_t  rsp,
    input  logic [63:0]          store_data,
    input  logic [63:0]          store_mask,
    input  logic [63:0]          load_data,
    output logic [2:0]           addr_low,
    output core_pkg::ls_size_t   size,
    output logic [63:0]          src2,
    output logic                 is_unsigned
);

    localparam logic [1:0] st_idle        = 2'd0;
    localparam logic [1:0] st_pending     = 2'd1;
    localparam logic [1:0] st_outstanding = 2'd2;

    logic [1:0]                state;
    logic [core_pkg::xlen-1:0] addr;
    logic                      ls_valid;
    logic                      in_window;
    logic                      need_flush;
    logic                      fire;
    logic                      done;

    assign addr      = instr.src1 + instr.imm;
    assign ls_valid  = instr.is_load | instr.is_store;
    assign in_window = (addr >= core_pkg::mmio_base) && (addr <= core_pkg::mmio_limit);

    // flush tag older than ours when wrap flags and index order disagree
    assign need_flush = flush.valid &
                        ((flush.tag.flag ^ instr.tag.flag) ^ (flush.tag.idx < instr.tag.idx));

    assign addr_low    = addr[2:0];
    assign size        = instr.size;
    assign src2        = instr.src2;
    assign is_unsigned = instr.is_unsigned;

    always_comb begin
        req.valid      = instr_valid & ls_valid & ~in_window & (state != st_outstanding);
        req.op         = instr.is_store ? tbus_pkg::tbus_write : tbus_pkg::tbus_read;
        req.index      = addr;
        req.write_data = instr.is_store ? store_data : '0;
        req.write_mask = instr.is_store ? store_mask : '0;
    end

    assign fire = req.valid & rsp.ready;
    assign done = (state == st_outstanding) & rsp.done;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (req.valid && !rsp.ready) begin
                        state <= st_pending;
                    end else if (fire) begin
                        state <= st_outstanding;
                    end
                end
                st_pending: begin
                    if (fire) begin
                        state <= st_outstanding;
                    end
                end
                st_outstanding: begin
                    if (done) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // stall from the issue cycle, released in the done cycle
    assign instr_ready = ~(((state != st_idle) | req.valid) & ~done);

    always_comb begin
        wb.valid   = instr_valid & ~need_flush;
        wb.need_wb = instr.is_load;
        wb.mmio    = instr_valid & ls_valid & in_window;
        wb.prd     = instr.prd;
        wb.tag     = instr.tag;
        wb.data    = (done & instr.is_load) ? load_data : '0;
    end

    // a request held off by the RAM keeps its fields until taken
    assert property (@(posedge clock) disable iff (!reset_n)
        (req.valid && !rsp.ready) |=> $stable(req));

    assert property (@(posedge clock) disable iff (!reset_n)
        rsp.done |-> (state == st_outstanding));

endmodule

// File: logic/lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
    parameter int ram_latency = 3,
    parameter int ram_words   = 256
) (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 instr_valid,
    input  core_pkg::mem_instr_t instr,
    input  core_pkg::flush_t     flush,
    output logic                 instr_ready,
    output core_pkg::wb_result_t wb
);

    tbus_pkg::tbus_req_t req;
    tbus_pkg::tbus_rsp_t rsp;
    logic [63:0]         store_data;
    logic [63:0]         store_mask;
    logic [63:0]         load_data;
    logic [2:0]          addr_low;
    core_pkg::ls_size_t  size;
    logic [63:0]         src2;
    logic                is_unsigned;

    mem_unit mem_unit_inst (
        .clock       (clock),
        .reset_n     (reset_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .flush       (flush),
        .instr_ready (instr_ready),
        .wb          (wb),
        .req         (req),
        .rsp         (rsp),
        .store_data  (store_data),
        .store_mask  (store_mask),
        .load_data   (load_data),
        .addr_low    (addr_low),
        .size        (size),
        .src2        (src2),
        .is_unsigned (is_unsigned)
    );

    store_align store_align_inst (
        .addr_low   (addr_low),
        .size       (size),
        .src2       (src2),
        .store_data (store_data),
        .store_mask (store_mask)
    );

    load_align load_align_inst (
        .addr_low    (addr_low),
        .size        (size),
        .is_unsigned (is_unsigned),
        .read_data   (rsp.read_data),
        .load_data   (load_data)
    );

    data_ram #(
        .ram_latency (ram_latency),
        .ram_words   (ram_words)
    ) data_ram_inst (
        .clock   (clock),
        .reset_n (reset_n),
        .req     (req),
        .rsp     (rsp)
    );

endmodule

// File: testbench/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;

    localparam int ram_latency  = 3;
    localparam int ram_words    = 256;
    localparam int n_random     = 120;
    // fill, random pairs and the directed accesses
    localparam int n_accesses   = ram_words + 2 * n_random + 40;
    localparam int limit_cycles = n_accesses * (ram_latency + 4) + 50;
    localparam core_pkg::flush_t no_flush = '0;

    typedef struct packed {
        logic               bus;
        logic               valid;
        logic               need_wb;
        logic               mmio;
        core_pkg::preg_t    prd;
        core_pkg::rob_tag_t tag;
        logic [63:0]        data;
    } expect_t;

    logic                 clock;
    logic                 reset_n;
    logic                 instr_valid;
    core_pkg::mem_instr_t instr;
    core_pkg::flush_t     flush;
    logic                 instr_ready;
    core_pkg::wb_result_t wb;

    expect_t    exp_wb;
    logic [7:0] shadow [ram_words * 8];
    logic       complete;
    int         completions;
    int         stall_count;
    int         errors;
    int         errors_base;
    int         tests_run;
    int         tests_failed;

    lsu_top #(
        .ram_latency (ram_latency),
        .ram_words   (ram_words)
    ) lsu_top_inst (
        .clock       (clock),
        .reset_n     (reset_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .flush       (flush),
        .instr_ready (instr_ready),
        .wb          (wb)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    assign complete = instr_valid & instr_ready;

    // cycles spent on the current access since its issue cycle
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            completions <= 0;
            stall_count <= 0;
        end else if (complete) begin
            completions <= completions + 1;
            stall_count <= 0;
        end else if (instr_valid) begin
            stall_count <= stall_count + 1;
        end
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        !instr_valid |-> (instr_ready && !wb.valid))
    else begin
        errors++;
        $display("Fail instr_ready expected 1 got %h, wb.valid expected 0 got %h",
                 $sampled(instr_ready), $sampled(wb.valid));
    end

    // a bus access stalls until exactly ram_latency cycles after issue
    assert property (@(posedge clock) disable iff (!reset_n)
        instr_valid |-> (instr_ready == (!exp_wb.bus || stall_count == ram_latency)))
    else begin
        errors++;
        $display("Fail instr_ready expected %h got %h",
                 $sampled(!exp_wb.bus || stall_count == ram_latency), $sampled(instr_ready));
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        complete |-> (wb.data == exp_wb.data))
    else begin
        errors++;
        $display("Fail wb.data expected %h got %h", $sampled(exp_wb.data), $sampled(wb.data));
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        complete |-> (wb.need_wb == exp_wb.need_wb))
    else begin
        errors++;
        $display("Fail wb.need_wb expected %h got %h",
                 $sampled(exp_wb.need_wb), $sampled(wb.need_wb));
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        complete |-> (wb.valid == exp_wb.valid))
    else begin
        errors++;
        $display("Fail wb.valid expected %h got %h", $sampled(exp_wb.valid), $sampled(wb.valid));
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        complete |-> (wb.mmio == exp_wb.mmio))
    else begin
        errors++;
        $display("Fail wb.mmio expected %h got %h", $sampled(exp_wb.mmio), $sampled(wb.mmio));
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        complete |-> (wb.prd == exp_wb.prd))
    else begin
        errors++;
        $display("Fail wb.prd expected %h got %h", $sampled(exp_wb.prd), $sampled(wb.prd));
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        complete |-> (wb.tag == exp_wb.tag))
    else begin
        errors++;
        $display("Fail wb.tag expected %h got %h", $sampled(exp_wb.tag), $sampled(wb.tag));
    end

    function automatic int byte_index(logic [63:0] addr, int i);
        return int'((addr >> 3) % ram_words) * 8 + int'(addr[2:0]) + i;
    endfunction

    function automatic logic in_window(logic [63:0] addr);
        return (addr >= core_pkg::mmio_base) && (addr <= core_pkg::mmio_limit);
    endfunction

    // an older flush sits on the same lap with a smaller index
    // or on the previous lap with an index not smaller
    function automatic logic flush_older(core_pkg::rob_tag_t ft, core_pkg::rob_tag_t it);
        if (ft.flag == it.flag) begin
            return ft.idx < it.idx;
        end
        return ft.idx >= it.idx;
    endfunction

    function automatic logic [63:0] predict_load(logic [63:0] addr, core_pkg::ls_size_t size,
                                                 logic is_unsigned);
        int          nbytes;
        logic [63:0] value;
        nbytes = 1 << int'(size);
        value  = '0;
        for (int i = 0; i < nbytes; i++) begin
            value[8*i +: 8] = shadow[byte_index(addr, i)];
        end
        if (!is_unsigned && nbytes < 8 && value[8*nbytes-1]) begin
            for (int b = 8 * nbytes; b < 64; b++) begin
                value[b] = 1'b1;
            end
        end
        return value;
    endfunction

    function automatic core_pkg::rob_tag_t rand_tag();
        return core_pkg::rob_tag_t'(6'($urandom));
    endfunction

    // one access from issue to completion followed by the shadow update
    task automatic run_access(input logic is_store, input core_pkg::ls_size_t size,
                              input logic is_unsigned, input logic [63:0] addr,
                              input logic [63:0] data, input core_pkg::rob_tag_t tag,
                              input core_pkg::flush_t fl);
        int                   start;
        logic [63:0]          base;
        logic                 mmio;
        core_pkg::mem_instr_t next;
        base             = {$urandom, $urandom};
        mmio             = in_window(addr);
        next.is_load     = !is_store;
        next.is_store    = is_store;
        next.is_unsigned = is_unsigned;
        next.size        = size;
        next.prd         = 6'($urandom);
        next.tag         = tag;
        next.src1        = base;
        next.src2        = data;
        next.imm         = addr - base;
        exp_wb.bus       = !mmio;
        exp_wb.valid     = !(fl.valid && flush_older(fl.tag, tag));
        exp_wb.need_wb   = !is_store;
        exp_wb.mmio      = mmio;
        exp_wb.prd       = next.prd;
        exp_wb.tag       = tag;
        exp_wb.data      = (!is_store && !mmio) ? predict_load(addr, size, is_unsigned) : '0;
        start            = completions;
        instr            = next;
        flush            = fl;
        instr_valid      = 1'b1;
        while (completions == start) begin
            @(negedge clock);
        end
        if (is_store && !mmio) begin
            for (int i = 0; i < (1 << int'(size)); i++) begin
                shadow[byte_index(addr, i)] = data[8*i +: 8];
            end
        end
        instr_valid = 1'b0;
        flush       = no_flush;
    endtask

    task automatic load(input core_pkg::ls_size_t size, input logic is_unsigned,
                        input logic [63:0] addr);
        run_access(1'b0, size, is_unsigned, addr, {$urandom, $urandom}, rand_tag(), no_flush);
    endtask

    task automatic store(input core_pkg::ls_size_t size, input logic [63:0] addr,
                         input logic [63:0] data);
        run_access(1'b1, size, 1'b0, addr, data, rand_tag(), no_flush);
    endtask

    task automatic report_test(input int num, input string name);
        tests_run++;
        if (errors == errors_base) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, name, errors - errors_base);
        end
        errors_base = errors;
    endtask

    function automatic logic [63:0] rand_addr(core_pkg::ls_size_t size);
        logic [63:0] word;
        logic [2:0]  off;
        // word range spans four RAM depths to exercise the wrap
        word = 64'($urandom_range(0, 4 * ram_words - 1));
        off  = 3'($urandom_range(0, 7)) & ~3'((1 << int'(size)) - 1);
        return {word[60:0], off};
    endfunction

    initial begin
        core_pkg::ls_size_t sz;
        logic [63:0]        addr;
        void'($urandom(32'h0bfc1adf));
        reset_n      = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        flush        = no_flush;
        exp_wb       = '0;
        errors       = 0;
        errors_base  = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (10) @(negedge clock);
        reset_n = 1'b1;
        repeat (5) @(negedge clock);
        report_test(1, "idle after reset");

        for (int w = 0; w < ram_words; w++) begin
            store(core_pkg::size_d, 64'(w) << 3, {$urandom, $urandom});
        end
        for (int i = 0; i < n_random; i++) begin
            sz   = core_pkg::ls_size_t'($urandom_range(0, 3));
            addr = rand_addr(sz);
            store(sz, addr, {$urandom, $urandom});
            sz = core_pkg::ls_size_t'(i % 4);
            load(sz, (i / 4) % 2 == 1,
                 {addr[63:3], 3'($urandom_range(0, 7)) & ~3'((1 << i % 4) - 1)});
        end
        report_test(2, "random stores and loads");

        store(core_pkg::size_d, 64'h88, 64'h0123_4567_89ab_cdef);
        store(core_pkg::size_b, 64'h8d, 64'h0000_0000_0000_00a5);
        load(core_pkg::size_d, 1'b0, 64'h88);
        store(core_pkg::size_h, 64'h8a, 64'h0000_0000_0000_5a5a);
        load(core_pkg::size_d, 1'b0, 64'h88);
        report_test(3, "partial stores keep other lanes");

        for (int i = 0; i < 8; i++) begin
            sz = core_pkg::ls_size_t'(i % 4);
            run_access(i < 4, sz, 1'b1, rand_addr(sz), {$urandom, $urandom}, rand_tag(), no_flush);
        end
        report_test(4, "bus access stall timing");

        store(core_pkg::size_d, core_pkg::mmio_base + 64'h8, {$urandom, $urandom});
        load(core_pkg::size_d, 1'b0, core_pkg::mmio_base + 64'h8);
        load(core_pkg::size_w, 1'b0, core_pkg::mmio_limit);
        load(core_pkg::size_d, 1'b0, (core_pkg::mmio_base + 64'h8) & 64'h7ff);
        load(core_pkg::size_d, 1'b0, core_pkg::mmio_base - 64'h8);
        load(core_pkg::size_d, 1'b0, core_pkg::mmio_limit + 64'h8);
        report_test(5, "mmio window");

        run_access(1'b0, core_pkg::size_d, 1'b0, 64'h40, '0, 6'h0a, '{valid: 1'b1, tag: 6'h03});
        run_access(1'b0, core_pkg::size_d, 1'b0, 64'h40, '0, 6'h0a, '{valid: 1'b1, tag: 6'h14});
        run_access(1'b0, core_pkg::size_w, 1'b0, 64'h44, '0, 6'h22, '{valid: 1'b1, tag: 6'h1e});
        run_access(1'b0, core_pkg::size_w, 1'b0, 64'h44, '0, 6'h22, '{valid: 1'b1, tag: 6'h25});
        run_access(1'b0, core_pkg::size_h, 1'b0, 64'h46, '0, 6'h1e, '{valid: 1'b1, tag: 6'h22});
        run_access(1'b0, core_pkg::size_h, 1'b0, 64'h46, '0, 6'h1e, '{valid: 1'b1, tag: 6'h1e});
        report_test(6, "flush tag check");

        repeat (2) @(negedge clock);
        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        repeat (limit_cycles) @(posedge clock);
        $display("watchdog expired after %0d cycles with the run still going", limit_cycles);
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: tb.f
logic/core_pkg.sv
logic/tbus_pkg.sv
logic/store_align.sv
logic/load_align.sv
logic/data_ram.sv
logic/mem_unit.sv
logic/lsu_top.sv
testbench/lsu_tb.sv
